// ==== hdl/hlcp_host_defines.svh ====
`ifndef HLCP_HOST_DEFINES_SVH
`define HLCP_HOST_DEFINES_SVH

// ----------------------------------------
// Bus and link widths
`define HLCP_ADDR_W             6       // Register address
`define HLCP_DATA_W             32      // Register data
`define HLCP_BYTE_W             8       // One link byte
`define HLCP_STEP_W             5       // Program counter
`define HLCP_IDX_W              4       // Frame byte index, counts to 8

// ----------------------------------------
// Peripheral register map
`define HLCP_REG_STXR           6'h02   // Slave transmit data
`define HLCP_REG_SRXR           6'h03   // Slave receive data
`define HLCP_REG_IER            6'h04   // Interrupt enable
`define HLCP_REG_ISR            6'h05   // Interrupt status, write 0 clears
`define HLCP_REG_LCMR           6'h06   // Link command
`define HLCP_REG_CONR           6'h08   // Control
`define HLCP_REG_OPR            6'h09   // Operation enable
`define HLCP_REG_SADDH          6'h0C   // Slave address high

// ----------------------------------------
// Program steps
`define HLCP_STEP_INIT_CONR     5'd0
`define HLCP_STEP_INIT_ISR      5'd1
`define HLCP_STEP_INIT_IER      5'd2
`define HLCP_STEP_INIT_LCMR     5'd3
`define HLCP_STEP_INIT_OPR      5'd4
`define HLCP_STEP_INIT_WAIT     5'd5    // First byte pending
`define HLCP_STEP_RX_READ       5'd6
`define HLCP_STEP_RX_ISR        5'd7
`define HLCP_STEP_RX_LCMR       5'd8
`define HLCP_STEP_RX_WAIT       5'd9    // Next byte or report
`define HLCP_STEP_TX_SETUP      5'd10
`define HLCP_STEP_TX_CONR       5'd11
`define HLCP_STEP_TX_ISR        5'd12
`define HLCP_STEP_TX_IER        5'd13
`define HLCP_STEP_TX_LCMR       5'd14
`define HLCP_STEP_TX_SYNC       5'd15   // Status poll, no wait
`define HLCP_STEP_TX0_DATA      5'd16
`define HLCP_STEP_TX0_ISR       5'd17
`define HLCP_STEP_TX0_LCMR      5'd18
`define HLCP_STEP_TX0_WAIT      5'd19   // First LED frame sent
`define HLCP_STEP_TX1_DATA      5'd20
`define HLCP_STEP_TX1_ISR       5'd21
`define HLCP_STEP_LAST          5'd22

// ----------------------------------------
// Frame decode
`define HLCP_CMD_REPORT         4'hE
`define HLCP_FRAME_BYTES        8
`define HLCP_WRAP_IDX           2       // Continuation restarts at data byte 0
`define HLCP_CTS_BIT            3       // CTS error slot in LED frame 1

`endif

// ==== hdl/hlcp_bus_pkg.sv ====
`include "hlcp_host_defines.svh"

// ----------------------------------------
// Register bus types
package hlcp_bus_pkg;

	// One register access as issued by the program
	typedef struct packed {
		logic                    write;   // 1 write, 0 read
		logic [`HLCP_ADDR_W-1:0] addr;
		logic [`HLCP_DATA_W-1:0] wdata;
	} bus_req_t;

	// Levels seen by the peripheral
	typedef struct packed {
		logic                    sel;     // High in SETUP and ACCESS
		logic                    enable;  // High in ACCESS only
		logic                    write;
		logic [`HLCP_ADDR_W-1:0] addr;
		logic [`HLCP_DATA_W-1:0] wdata;
	} bus_port_t;

	// Transaction phase
	typedef enum logic [1:0] {
		IDLE   = 2'd0,
		SETUP  = 2'd1,
		ACCESS = 2'd2
	} bus_phase_e;

endpackage

// ==== hdl/hlcp_frame_pkg.sv ====
`include "hlcp_host_defines.svh"

// ----------------------------------------
// Received frame types
package hlcp_frame_pkg;

	// Header split into check and command nibbles
	typedef struct packed {
		logic [3:0] crc;                      // High nibble
		logic [3:0] cmd;                      // Low nibble
	} frame_hdr_f_t;

	// Header byte, raw as read or decoded
	typedef union packed {
		logic [`HLCP_BYTE_W-1:0] raw;         // Byte 0 from SRXR
		frame_hdr_f_t            f;
	} frame_hdr_u;

	// Whole eight-byte frame
	typedef struct packed {
		frame_hdr_u                hdr;       // Byte 0
		logic [`HLCP_BYTE_W-1:0]   id;        // Byte 1, operand ID
		logic [6*`HLCP_BYTE_W-1:0] data;      // Bytes 7..2, byte 2 lowest
	} frame_t;

endpackage

// ==== hdl/hlcp_step_sequencer.sv ====
`timescale 1ns/1ps
`include "hlcp_host_defines.svh"

module hlcp_step_sequencer (
	input  logic                    sys_clk,
	input  logic                    sys_resetb,
	input  logic                    irq_i,         // Peripheral interrupt
	input  logic [3:0]              cmd_i,         // Command nibble of frame
	input  logic [`HLCP_BYTE_W-1:0] led0_i,        // LED error frame 0
	input  logic [`HLCP_BYTE_W-1:0] led1_i,        // LED error frame 1
	input  logic                    done_i,        // End of ACCESS
	output logic                    run_o,         // Bus master may start
	output hlcp_bus_pkg::bus_req_t  req_o,         // Request of this step
	output logic                    rx_capture_o   // SRXR read completes
);

	logic [`HLCP_STEP_W-1:0] step_q;               // Program counter
	logic [`HLCP_STEP_W-1:0] step_nxt;
	logic                    wait_step;            // Holding for irq

	function automatic logic is_wait(input logic [`HLCP_STEP_W-1:0] step);
		return (step == `HLCP_STEP_INIT_WAIT) || (step == `HLCP_STEP_RX_WAIT) ||
			(step == `HLCP_STEP_TX0_WAIT);
	endfunction

	assign wait_step = is_wait(step_q);

	// ----------------------------------------
	// Next step
	always_comb begin
		step_nxt = step_q;
		case (step_q)
			`HLCP_STEP_INIT_WAIT: if (irq_i) step_nxt = `HLCP_STEP_RX_READ;
			`HLCP_STEP_RX_WAIT: begin
				if (irq_i && (cmd_i == `HLCP_CMD_REPORT))
					step_nxt = `HLCP_STEP_TX_SETUP;     // Answer REPORT
				else if (irq_i)
					step_nxt = `HLCP_STEP_RX_READ;      // Next byte
			end
			`HLCP_STEP_TX0_WAIT: if (irq_i) step_nxt = `HLCP_STEP_TX1_DATA;
			`HLCP_STEP_LAST: if (done_i) step_nxt = `HLCP_STEP_INIT_CONR;
			default: if (done_i) step_nxt = step_q + `HLCP_STEP_W'(1);
		endcase
	end

	always_ff @(posedge sys_clk or negedge sys_resetb) begin
		if (!sys_resetb) begin
			step_q <= `HLCP_STEP_INIT_CONR;
			run_o  <= 1'b0;                        // Raised one cycle after reset
		end else begin
			step_q <= step_nxt;
			run_o  <= !is_wait(step_nxt);          // Drops as a wait step is entered
		end
	end

	// ----------------------------------------
	// Step table
	always_comb begin
		req_o.write = 1'b1;
		req_o.addr  = `HLCP_REG_ISR;                // ISR=0 unless listed
		req_o.wdata = '0;
		case (step_q)
			`HLCP_STEP_INIT_CONR: begin
				req_o.addr  = `HLCP_REG_CONR;
				req_o.wdata = `HLCP_DATA_W'(32'h1);  // Receive mode
			end
			`HLCP_STEP_INIT_IER, `HLCP_STEP_TX_IER: begin
				req_o.addr  = `HLCP_REG_IER;
				req_o.wdata = `HLCP_DATA_W'(32'hFF); // All sources
			end
			`HLCP_STEP_INIT_LCMR, `HLCP_STEP_TX_LCMR: begin
				req_o.addr  = `HLCP_REG_LCMR;
				req_o.wdata = `HLCP_DATA_W'(32'h1);
			end
			`HLCP_STEP_INIT_OPR: begin
				req_o.addr  = `HLCP_REG_OPR;
				req_o.wdata = `HLCP_DATA_W'(32'h1);  // Link on
			end
			`HLCP_STEP_RX_READ: begin
				req_o.write = 1'b0;
				req_o.addr  = `HLCP_REG_SRXR;
			end
			`HLCP_STEP_RX_LCMR, `HLCP_STEP_TX0_LCMR: begin
				req_o.addr  = `HLCP_REG_LCMR;
				req_o.wdata = `HLCP_DATA_W'(32'h4);  // Continue link
			end
			`HLCP_STEP_TX_SETUP: req_o.addr = `HLCP_REG_SADDH;
			`HLCP_STEP_TX_CONR: begin
				req_o.addr  = `HLCP_REG_CONR;
				req_o.wdata = `HLCP_DATA_W'(32'h3);  // Transmit mode
			end
			`HLCP_STEP_TX_SYNC: req_o.write = 1'b0;  // Status read
			`HLCP_STEP_TX0_DATA: begin
				req_o.addr  = `HLCP_REG_STXR;
				req_o.wdata = `HLCP_DATA_W'(led0_i);
			end
			`HLCP_STEP_TX1_DATA: begin
				req_o.addr  = `HLCP_REG_STXR;
				req_o.wdata = `HLCP_DATA_W'(led1_i);
			end
			`HLCP_STEP_LAST: begin
				req_o.addr  = `HLCP_REG_LCMR;
				req_o.wdata = `HLCP_DATA_W'(32'h6);  // Last frame
			end
			default: ;                               // ISR clears and waits
		endcase
	end

	assign rx_capture_o = done_i && (step_q == `HLCP_STEP_RX_READ);

	// No transaction runs or completes while holding for the interrupt
	a_wait_idle: assert property (@(posedge sys_clk) disable iff (!sys_resetb)
		wait_step |-> (!run_o && !done_i));

endmodule

// ==== hdl/hlcp_bus_master.sv ====
`timescale 1ns/1ps
`include "hlcp_host_defines.svh"

module hlcp_bus_master (
	input  logic                    sys_clk,
	input  logic                    sys_resetb,
	input  logic                    run_i,          // Start level
	input  hlcp_bus_pkg::bus_req_t  req_i,          // Sampled in IDLE
	input  logic [`HLCP_DATA_W-1:0] bus_rdata_i,    // Peripheral read data
	output hlcp_bus_pkg::bus_port_t bus_o,          // Registered bus levels
	output logic                    done_o,         // Last cycle of ACCESS
	output logic                    rdata_valid_o   // Read data on bus now
);

	import hlcp_bus_pkg::*;

	bus_phase_e phase_q;

	// ----------------------------------------
	// Phase FSM and bus levels
	always_ff @(posedge sys_clk or negedge sys_resetb) begin
		if (!sys_resetb) begin
			phase_q <= IDLE;
			bus_o   <= '0;
		end else begin
			case (phase_q)
				IDLE: begin
					if (run_i) begin
						phase_q      <= SETUP;
						bus_o.sel    <= 1'b1;
						bus_o.write  <= req_i.write;
						bus_o.addr   <= req_i.addr;
						bus_o.wdata  <= req_i.wdata;
					end
				end
				SETUP: begin
					phase_q      <= ACCESS;
					bus_o.enable <= 1'b1;               // Peripheral acts now
				end
				default: begin
					phase_q      <= IDLE;               // At least one idle cycle
					bus_o.sel    <= 1'b0;
					bus_o.enable <= 1'b0;
					bus_o.write  <= 1'b0;
				end
			endcase
		end
	end

	assign done_o        = (phase_q == ACCESS);
	assign rdata_valid_o = (phase_q == ACCESS) && !bus_o.write;

	// ACCESS only follows a SETUP cycle of the same transfer
	a_enable_sel: assert property (@(posedge sys_clk) disable iff (!sys_resetb)
		bus_o.enable |-> (bus_o.sel && $past(bus_o.sel && !bus_o.enable)));

	// Peripheral must present defined read data in ACCESS
	a_rdata_known: assert property (@(posedge sys_clk) disable iff (!sys_resetb)
		rdata_valid_o |-> !$isunknown(bus_rdata_i));

endmodule

// ==== hdl/hlcp_rx_frame.sv ====
`timescale 1ns/1ps
`include "hlcp_host_defines.svh"

module hlcp_rx_frame (
	input  logic                    sys_clk,
	input  logic                    sys_resetb,
	input  logic                    irq_i,          // Peripheral interrupt
	input  logic                    init_i,         // Link init, clears index
	input  logic                    link_start_i,   // New frame on the link
	input  logic                    capture_i,      // SRXR read in ACCESS
	input  logic [`HLCP_DATA_W-1:0] rdata_i,
	output hlcp_frame_pkg::frame_t  frame_o,
	output logic [1:0]              loop_count_o    // Continuation passes
);

	logic                    irq_q;                 // Last cycle's irq
	logic                    irq_fall;
	logic [`HLCP_IDX_W-1:0]  idx_q;                 // Next byte slot
	logic                    idx_full;
	logic [`HLCP_BYTE_W-1:0] byte_q [`HLCP_FRAME_BYTES];

	// ----------------------------------------
	// Interrupt edge and byte index
	always_ff @(posedge sys_clk or negedge sys_resetb) begin
		if (!sys_resetb)
			irq_q <= 1'b0;
		else
			irq_q <= irq_i;
	end

	assign irq_fall = irq_q && !irq_i;              // ISR cleared by host
	assign idx_full = (idx_q == `HLCP_IDX_W'(`HLCP_FRAME_BYTES));

	always_ff @(posedge sys_clk or negedge sys_resetb) begin
		if (!sys_resetb)
			idx_q <= '0;
		else if (init_i || link_start_i)
			idx_q <= '0;
		else if (idx_full)
			idx_q <= `HLCP_IDX_W'(`HLCP_WRAP_IDX) + `HLCP_IDX_W'(irq_fall); // Keep a late edge
		else if (irq_fall)
			idx_q <= idx_q + `HLCP_IDX_W'(1);
	end

	always_ff @(posedge sys_clk or negedge sys_resetb) begin
		if (!sys_resetb)
			loop_count_o <= 2'd0;
		else if (init_i)
			loop_count_o <= 2'd0;
		else if (idx_full)
			loop_count_o <= loop_count_o + 2'd1;   // One per wrap
	end

	// ----------------------------------------
	// Frame buffer
	always_ff @(posedge sys_clk or negedge sys_resetb) begin
		if (!sys_resetb) begin
			for (int i = 0; i < `HLCP_FRAME_BYTES; i++)
				byte_q[i] <= '0;
		end else if (capture_i && !idx_full) begin
			byte_q[idx_q[2:0]] <= rdata_i[`HLCP_BYTE_W-1:0]; // Low byte only
		end
	end

	always_comb begin
		frame_o.hdr.raw = byte_q[0];
		frame_o.id      = byte_q[1];
		frame_o.data    = {byte_q[7], byte_q[6], byte_q[5],
			byte_q[4], byte_q[3], byte_q[2]};
	end

	a_idx_range: assert property (@(posedge sys_clk) disable iff (!sys_resetb)
		idx_q <= `HLCP_IDX_W'(`HLCP_FRAME_BYTES));

endmodule

// ==== hdl/hlcp_error_report.sv ====
`timescale 1ns/1ps
`include "hlcp_host_defines.svh"

module hlcp_error_report (
	input  logic                    sys_clk,
	input  logic                    sys_resetb,
	input  logic                    init_i,         // Capture LED inputs
	input  logic                    link_stop_i,
	input  logic                    addr_match_i,   // Stop was addressed to us
	input  logic                    cts_error_i,    // Clear-to-send fault
	input  logic [`HLCP_BYTE_W-1:0] led_frame0_i,
	input  logic [`HLCP_BYTE_W-1:0] led_frame1_i,
	output logic [`HLCP_BYTE_W-1:0] led0_o,         // Data for step 16
	output logic [`HLCP_BYTE_W-1:0] led1_o          // Data for step 20
);

	logic flush_q;                                  // Flush level
	logic cts_q;                                    // Sticky CTS error

	always_ff @(posedge sys_clk or negedge sys_resetb) begin
		if (!sys_resetb)
			flush_q <= 1'b0;
		else if (link_stop_i && addr_match_i)
			flush_q <= !flush_q;                   // Toggles per addressed stop
	end

	always_ff @(posedge sys_clk or negedge sys_resetb) begin
		if (!sys_resetb)
			cts_q <= 1'b0;
		else if (flush_q)
			cts_q <= 1'b0;
		else if (cts_error_i)
			cts_q <= 1'b1;
	end

	// ----------------------------------------
	// LED error frames
	always_ff @(posedge sys_clk or negedge sys_resetb) begin
		if (!sys_resetb) begin
			led0_o <= '1;                          // No report captured yet
			led1_o <= '1;
		end else if (flush_q) begin
			led0_o <= '0;
			led1_o <= '0;
		end else if (init_i) begin
			led0_o <= led_frame0_i;
			led1_o <= led_frame1_i;
			led1_o[`HLCP_CTS_BIT] <= cts_q;        // CTS slot overrides input
		end
	end

endmodule

// ==== hdl/hlcp_host_top.sv ====
`timescale 1ns/1ps
`include "hlcp_host_defines.svh"

module hlcp_host_top (
	input  logic                    sys_clk,
	input  logic                    sys_resetb,
	input  logic                    irq_i,          // Peripheral interrupt
	input  logic [`HLCP_DATA_W-1:0] bus_rdata_i,
	input  logic                    init_i,
	input  logic                    link_start_i,
	input  logic                    link_stop_i,
	input  logic                    addr_match_i,
	input  logic                    cts_error_i,
	input  logic [`HLCP_BYTE_W-1:0] led_frame0_i,
	input  logic [`HLCP_BYTE_W-1:0] led_frame1_i,
	output hlcp_bus_pkg::bus_port_t bus_o,
	output hlcp_frame_pkg::frame_t  frame_o,
	output logic [1:0]              loop_count_o
);

	import hlcp_bus_pkg::*;

	logic                    run;
	bus_req_t                req;
	logic                    done;
	logic                    rdata_valid;
	logic                    rx_capture;
	logic                    capture;              // Qualified read strobe
	logic [`HLCP_BYTE_W-1:0] led0;
	logic [`HLCP_BYTE_W-1:0] led1;

	// ----------------------------------------
	// Program and bus
	hlcp_step_sequencer u_seq (
		.sys_clk      (sys_clk),
		.sys_resetb   (sys_resetb),
		.irq_i        (irq_i),
		.cmd_i        (frame_o.hdr.f.cmd),
		.led0_i       (led0),
		.led1_i       (led1),
		.done_i       (done),
		.run_o        (run),
		.req_o        (req),
		.rx_capture_o (rx_capture)
	);

	hlcp_bus_master u_bus (
		.sys_clk       (sys_clk),
		.sys_resetb    (sys_resetb),
		.run_i         (run),
		.req_i         (req),
		.bus_rdata_i   (bus_rdata_i),
		.bus_o         (bus_o),
		.done_o        (done),
		.rdata_valid_o (rdata_valid)
	);

	assign capture = rx_capture && rdata_valid;     // Read phase only

	// ----------------------------------------
	// Receive and report
	hlcp_rx_frame u_rx (
		.sys_clk      (sys_clk),
		.sys_resetb   (sys_resetb),
		.irq_i        (irq_i),
		.init_i       (init_i),
		.link_start_i (link_start_i),
		.capture_i    (capture),
		.rdata_i      (bus_rdata_i),
		.frame_o      (frame_o),
		.loop_count_o (loop_count_o)
	);

	hlcp_error_report u_err (
		.sys_clk      (sys_clk),
		.sys_resetb   (sys_resetb),
		.init_i       (init_i),
		.link_stop_i  (link_stop_i),
		.addr_match_i (addr_match_i),
		.cts_error_i  (cts_error_i),
		.led_frame0_i (led_frame0_i),
		.led_frame1_i (led_frame1_i),
		.led0_o       (led0),
		.led1_o       (led1)
	);

endmodule

// ==== testbench/tb_hlcp_host.sv ====
`timescale 1ns/1ps
`include "hlcp_host_defines.svh"

module tb_hlcp_host;

	import hlcp_bus_pkg::*;
	import hlcp_frame_pkg::*;

	localparam int CLK_NS       = 10;
	localparam int RESET_CYCLES = 10;
	localparam int QUIET_CYCLES = 20;          // Idle window after init program
	localparam int TX_DELAY     = 4;           // Link time of one LED frame
	localparam int MAX_TXN      = 200;
	localparam int CYC_PER_TXN  = 5;           // Three bus cycles plus handshake slack
	localparam int WATCHDOG_NS  = (RESET_CYCLES + QUIET_CYCLES + MAX_TXN * CYC_PER_TXN) * CLK_NS;

	logic                    sys_clk;
	logic                    sys_resetb;
	logic                    irq_i = 1'b0;     // Owned by peripheral model
	logic [`HLCP_DATA_W-1:0] bus_rdata_i;      // Pending link byte
	logic                    init_i;
	logic                    link_start_i;
	logic                    link_stop_i;
	logic                    addr_match_i;
	logic                    cts_error_i;
	logic [`HLCP_BYTE_W-1:0] led_frame0_i;
	logic [`HLCP_BYTE_W-1:0] led_frame1_i;
	bus_port_t               dut_bus;
	frame_t                  dut_frame;
	logic [1:0]              loop_count;

	logic [`HLCP_ADDR_W-1:0] log_addr [$];     // Every bus write, in order
	logic [`HLCP_DATA_W-1:0] log_data [$];
	int unsigned             wr_count [64] = '{default: 0};
	logic                    tx_mode = 1'b0;   // CONR=3 seen
	int                      tx_wait = 0;
	int unsigned             raise_cnt = 0;    // Byte offers from stimulus
	int unsigned             raised_cnt = 0;   // Offers turned into irq
	logic                    bus_wr;
	logic                    quiet = 1'b0;     // No bus traffic allowed
	logic [`HLCP_BYTE_W-1:0] rx_bytes [`HLCP_FRAME_BYTES];
	logic [`HLCP_BYTE_W-1:0] led_a0;
	logic [`HLCP_BYTE_W-1:0] led_a1;
	logic [`HLCP_BYTE_W-1:0] led_b0;
	logic [`HLCP_BYTE_W-1:0] led_b1;
	int                      seed = 30;
	int                      checks = 0;
	int                      errors = 0;
	int                      assert_errors = 0;
	int                      checks_mark = 0;
	int                      errors_mark = 0;
	int                      tests = 0;

	hlcp_host_top dut0 (
		.sys_clk      (sys_clk),
		.sys_resetb   (sys_resetb),
		.irq_i        (irq_i),
		.bus_rdata_i  (bus_rdata_i),
		.init_i       (init_i),
		.link_start_i (link_start_i),
		.link_stop_i  (link_stop_i),
		.addr_match_i (addr_match_i),
		.cts_error_i  (cts_error_i),
		.led_frame0_i (led_frame0_i),
		.led_frame1_i (led_frame1_i),
		.bus_o        (dut_bus),
		.frame_o      (dut_frame),
		.loop_count_o (loop_count)
	);

	initial begin
		sys_clk = 1'b0;
		forever #(CLK_NS / 2) sys_clk = ~sys_clk;
	end

	// ----------------------------------------
	// Peripheral model
	assign bus_wr = dut_bus.sel && dut_bus.enable && dut_bus.write;

	always @(posedge sys_clk) begin
		if (bus_wr) begin
			log_addr.push_back(dut_bus.addr);
			log_data.push_back(dut_bus.wdata);
			wr_count[dut_bus.addr] <= wr_count[dut_bus.addr] + 1;
			if (dut_bus.addr == `HLCP_REG_CONR)
				tx_mode <= (dut_bus.wdata == `HLCP_DATA_W'(3));
		end
		if (bus_wr && dut_bus.addr == `HLCP_REG_ISR)
			irq_i <= 1'b0;                      // Status cleared by host
		else if (raised_cnt != raise_cnt) begin
			irq_i      <= 1'b1;                 // Byte pending
			raised_cnt <= raise_cnt;
		end else if (tx_wait == 1)
			irq_i <= 1'b1;                      // LED frame sent
		if (bus_wr && tx_mode && dut_bus.addr == `HLCP_REG_LCMR &&
			dut_bus.wdata == `HLCP_DATA_W'(4))
			tx_wait <= TX_DELAY;
		else if (tx_wait > 0)
			tx_wait <= tx_wait - 1;
	end

	// ----------------------------------------
	// Checking
	task automatic flag_error(input string msg);
		assert_errors++;
		$display("CHECK FAILED at %0d ns: %s", $time, msg);
	endtask

	task automatic check_true(input bit ok, input string msg);
		checks++;
		assert (ok) else begin
			errors++;
			$display("CHECK FAILED at %0d ns: %s", $time, msg);
		end
	endtask

	a_quiet: assert property (@(posedge sys_clk) quiet |-> !dut_bus.sel)
		else flag_error("bus transaction before the interrupt was raised");

	a_stxr_byte: assert property (@(posedge sys_clk)
		(bus_wr && dut_bus.addr == `HLCP_REG_STXR) |-> (dut_bus.wdata[31:8] == 24'd0))
		else flag_error("STXR write carries data above the low byte");

	task automatic end_test(input string name);
		int total;
		total = errors + assert_errors;
		$display("%s: %0d checks, %0d errors", name, checks - checks_mark, total - errors_mark);
		checks_mark = checks;
		errors_mark = total;
		tests++;
	endtask

	function automatic logic [7:0] rand_byte();
		return 8'($random(seed));
	endfunction

	// ----------------------------------------
	// Stimulus helpers
	task automatic wait_writes(input logic [`HLCP_ADDR_W-1:0] addr, input int unsigned prev);
		while (wr_count[addr] == prev)
			@(posedge sys_clk);
	endtask

	// Offer one byte, return once the host has re-armed the link
	task automatic send_byte(input logic [7:0] b);
		int unsigned n;
		@(negedge sys_clk);
		n = wr_count[`HLCP_REG_LCMR];
		@(posedge sys_clk);
		bus_rdata_i <= {24'd0, b};
		raise_cnt   <= raise_cnt + 1;
		wait_writes(`HLCP_REG_LCMR, n);
	endtask

	task automatic pulse_init(input logic [7:0] f0, input logic [7:0] f1);
		@(posedge sys_clk);
		led_frame0_i <= f0;
		led_frame1_i <= f1;
		init_i       <= 1'b1;
		@(posedge sys_clk);
		init_i       <= 1'b0;
		led_frame0_i <= ~f0;                    // Inputs move on after capture
		led_frame1_i <= ~f1;
	endtask

	task automatic check_frame(input string tag);
		@(negedge sys_clk);
		check_true(dut_frame.hdr.f.cmd == rx_bytes[0][3:0], {tag, ": cmd nibble wrong"});
		check_true(dut_frame.hdr.f.crc == rx_bytes[0][7:4], {tag, ": crc nibble wrong"});
		check_true(dut_frame.id == rx_bytes[1],
			$sformatf("%s: id %h, expected %h", tag, dut_frame.id, rx_bytes[1]));
		check_true(dut_frame.data == {rx_bytes[7], rx_bytes[6], rx_bytes[5], rx_bytes[4],
			rx_bytes[3], rx_bytes[2]}, $sformatf("%s: data %h", tag, dut_frame.data));
	endtask

	// REPORT header, then the transmit program and its two STXR bytes
	task automatic run_report(input logic [7:0] exp0, input logic [7:0] exp1);
		logic [7:0]  hdr;
		logic [7:0]  sent [$];
		int          mark;
		int unsigned opr_n;
		hdr      = rand_byte();
		hdr[3:0] = `HLCP_CMD_REPORT;
		@(posedge sys_clk);
		link_start_i <= 1'b1;                   // Header goes to byte 0
		@(posedge sys_clk);
		link_start_i <= 1'b0;
		send_byte(hdr);
		@(negedge sys_clk);
		mark  = log_addr.size();
		opr_n = wr_count[`HLCP_REG_OPR];
		@(posedge sys_clk);
		raise_cnt <= raise_cnt + 1;
		wait_writes(`HLCP_REG_OPR, opr_n);      // Back through init program
		@(negedge sys_clk);
		for (int k = mark; k < log_addr.size(); k++)
			if (log_addr[k] == `HLCP_REG_STXR)
				sent.push_back(log_data[k][7:0]);
		check_true(log_addr[mark] == `HLCP_REG_SADDH, "transmit program does not start at SADDH");
		check_true(sent.size() == 2, $sformatf("%0d STXR writes, expected 2", sent.size()));
		check_true(sent[0] == exp0, $sformatf("LED frame 0 %h, expected %h", sent[0], exp0));
		check_true(sent[1] == exp1, $sformatf("LED frame 1 %h, expected %h", sent[1], exp1));
	endtask

	// ----------------------------------------
	// Test sequence
	initial begin
		int total;
		sys_resetb   = 1'b0;
		bus_rdata_i  = '0;
		init_i       = 1'b0;
		link_start_i = 1'b0;
		link_stop_i  = 1'b0;
		addr_match_i = 1'b0;
		cts_error_i  = 1'b0;
		led_frame0_i = '0;
		led_frame1_i = '0;
		led_a0 = rand_byte();
		led_a1 = rand_byte() | 8'h08;          // Bit 3 must be masked by the latch
		led_b0 = rand_byte();
		led_b1 = rand_byte() & 8'hF7;
		for (int i = 0; i < `HLCP_FRAME_BYTES; i++)
			rx_bytes[i] = rand_byte();
		if (rx_bytes[0][3:0] == `HLCP_CMD_REPORT)
			rx_bytes[0][3:0] = 4'h1;
		repeat (RESET_CYCLES) @(posedge sys_clk);
		sys_resetb <= 1'b1;
		pulse_init(led_a0, led_a1);

		wait_writes(`HLCP_REG_OPR, 0);
		@(posedge sys_clk);
		quiet <= 1'b1;
		repeat (QUIET_CYCLES) @(posedge sys_clk);
		quiet <= 1'b0;
		@(negedge sys_clk);
		check_true(log_addr.size() == 5, $sformatf("%0d init writes, expected 5", log_addr.size()));
		check_true(log_addr[0] == `HLCP_REG_CONR && log_data[0] == 32'h1, "init write 0");
		check_true(log_addr[1] == `HLCP_REG_ISR && log_data[1] == 32'h0, "init write 1");
		check_true(log_addr[2] == `HLCP_REG_IER && log_data[2] == 32'hFF, "init write 2");
		check_true(log_addr[3] == `HLCP_REG_LCMR && log_data[3] == 32'h1, "init write 3");
		check_true(log_addr[4] == `HLCP_REG_OPR && log_data[4] == 32'h1, "init write 4");
		end_test("test 1 init program");

		for (int i = 0; i < `HLCP_FRAME_BYTES; i++)
			send_byte(rx_bytes[i]);
		check_frame("full frame");
		check_true(loop_count == 2'd1, $sformatf("loop count %0d, expected 1", loop_count));
		end_test("test 2 frame decode");

		for (int i = `HLCP_WRAP_IDX; i < `HLCP_FRAME_BYTES; i++) begin
			rx_bytes[i] = rand_byte();
			send_byte(rx_bytes[i]);
		end
		check_frame("continuation");
		check_true(loop_count == 2'd2, $sformatf("loop count %0d, expected 2", loop_count));
		end_test("test 3 continuation");

		run_report(led_a0, led_a1 & 8'hF7);
		@(posedge sys_clk);
		cts_error_i <= 1'b1;
		@(posedge sys_clk);
		cts_error_i <= 1'b0;
		pulse_init(led_b0, led_b1);
		run_report(led_b0, led_b1 | 8'h08);
		end_test("test 4 error report");

		@(posedge sys_clk);
		link_stop_i  <= 1'b1;
		addr_match_i <= 1'b1;
		@(posedge sys_clk);
		link_stop_i  <= 1'b0;
		addr_match_i <= 1'b0;
		run_report(8'h00, 8'h00);
		end_test("test 5 flush");

		total = errors + assert_errors;
		$display("summary: %0d tests, %0d checks, %0d errors", tests, checks, total);
		if (total == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("TIMEOUT: the host did not finish the test sequence in time");
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

// ==== compile.f ====
+incdir+hdl
hdl/hlcp_bus_pkg.sv
hdl/hlcp_frame_pkg.sv
hdl/hlcp_step_sequencer.sv
hdl/hlcp_bus_master.sv
hdl/hlcp_rx_frame.sv
hdl/hlcp_error_report.sv
hdl/hlcp_host_top.sv
testbench/tb_hlcp_host.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f compile.f --top-module tb_hlcp_host -o tb_sim; then
	echo "Verilator build failed"
	exit 1
fi

if ! out=$(./obj_dir/tb_sim); then
	printf '%s\n' "$out"
	echo "Simulation exited with an error"
	exit 1
fi
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "ALL CHECKS PASSED"; then
	exit 0
fi
exit 1
